// ==== Bender.yml ====
package:
  name: exe_apb_alu

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exe_alu_pkg.sv
      - verilog/exe_apb_pkg.sv
      - verilog/kogge_stone_adder.sv
      - verilog/exe_alu.sv
      - verilog/exe_apb_regs.sv
      - verilog/exe_apb_alu.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/exe_apb_alu_assert.sv
      - tests/exe_apb_alu_tb.sv

// ==== project.f ====
+incdir+verilog
verilog/exe_alu_pkg.sv
verilog/exe_apb_pkg.sv
verilog/kogge_stone_adder.sv
verilog/exe_alu.sv
verilog/exe_apb_regs.sv
verilog/exe_apb_alu.sv
tests/exe_apb_alu_assert.sv
tests/exe_apb_alu_tb.sv

// ==== tests/exe_apb_alu_assert.sv ====
`timescale 1ns/1ps

module exe_apb_alu_assert (
    input logic                  i_clk,
    input logic                  i_reset,
    input exe_apb_pkg::apb_req_t i_apb,
    input exe_apb_pkg::apb_rsp_t o_apb
);

    // zero-wait slave only answers inside an access cycle
    property p_ready_in_access;
        @(posedge i_clk) disable iff (i_reset)
            o_apb.pready |-> (i_apb.psel && i_apb.penable);
    endproperty

    property p_err_with_ready;
        @(posedge i_clk) disable iff (i_reset)
            o_apb.pslverr |-> o_apb.pready;
    endproperty

    property p_ready_after_reset;
        @(posedge i_clk) i_reset |=> !o_apb.pready;
    endproperty

    a_ready_in_access:   assert property (p_ready_in_access)
        else $error("pready high outside an access cycle");
    a_err_with_ready:    assert property (p_err_with_ready)
        else $error("pslverr high without pready");
    a_ready_after_reset: assert property (p_ready_after_reset)
        else $error("pready high in the cycle after reset");

endmodule

bind exe_apb_regs exe_apb_alu_assert i_assert (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_apb   (i_apb),
    .o_apb   (o_apb)
);

// ==== tests/exe_apb_alu_tb.sv ====
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_apb_alu_tb;
    localparam int W           = `EXE_DATA_W;
    localparam int NUM_RANDOM  = 200;
    localparam int NUM_CORNERS = 6;
    localparam int NUM_ILLEGAL = 3;
    // six transfers per operation, plus reset, readback and bus error tests
    localparam int NUM_XFERS   = 6 + 8 + 20 + 6 * (NUM_RANDOM + NUM_CORNERS + NUM_ILLEGAL);
    localparam int WATCHDOG_CYCLES = 8 * NUM_XFERS + 100;

    logic                  i_clk;
    logic                  i_reset;
    exe_apb_pkg::apb_req_t apb_req;
    exe_apb_pkg::apb_rsp_t apb_rsp;

    logic [31:0]  lcg_state;
    logic [4:0]   op_list [10];
    logic [W-1:0] a;
    logic [W-1:0] rs2;
    logic [W-1:0] imm;
    logic [W-1:0] r;
    logic [W-1:0] ctrl;
    int           errors;
    int           tests_run;
    int           tests_failed;
    int           test_start_errors;

    exe_apb_alu i_dut (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_apb   (apb_req),
        .o_apb   (apb_rsp)
    );

    always #2 i_clk = ~i_clk;

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // returns {n, z, c, v, result}
    function automatic logic [W+3:0] ref_alu(input logic [W-1:0] fa, input logic [W-1:0] fb,
                                             input logic [4:0] op);
        logic [W-1:0] bb;
        logic [W:0]   s;
        logic [W-1:0] res;
        logic [4:0]   sh;
        logic         v;
        bb = op[4] ? ~fb : fb;
        s  = {1'b0, fa} + {1'b0, bb} + (W+1)'(op[4]);
        // both addends share a sign that the sum lost
        v  = (fa[W-1] == bb[W-1]) && (s[W-1] != fa[W-1]);
        sh = fb[4:0];
        case (op)
            exe_alu_pkg::OP_ADD,
            exe_alu_pkg::OP_SUB:  res = s[W-1:0];
            exe_alu_pkg::OP_AND:  res = fa & fb;
            exe_alu_pkg::OP_OR:   res = fa | fb;
            exe_alu_pkg::OP_XOR:  res = fa ^ fb;
            exe_alu_pkg::OP_SLL:  res = fa << sh;
            exe_alu_pkg::OP_SRL:  res = fa >> sh;
            exe_alu_pkg::OP_SRA:  res = (fa >> sh) | (fa[W-1] ? ~({W{1'b1}} >> sh) : '0);
            exe_alu_pkg::OP_SLT:  res = W'($signed(fa) < $signed(fb));
            exe_alu_pkg::OP_SLTU: res = W'(fa < fb);
            default:              res = '0;
        endcase
        return {s[W-1], (s[W-1:0] == '0), s[W], v, res};
    endfunction

    // one setup and one access cycle, outputs sampled mid access cycle
    task automatic bus_transfer(input logic [7:0] addr, input logic write,
                                input logic [W-1:0] wdata,
                                output logic [W-1:0] rdata, output logic err);
        @(posedge i_clk);
        #1;
        apb_req.paddr   = addr;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge i_clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge i_clk);
        if (apb_rsp.pready !== 1'b1) begin
            errors++;
            $display("[ERROR] %0t: pready low in access cycle at 0x%02h", $time, addr);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge i_clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [W-1:0] data,
                             input logic exp_err);
        logic [W-1:0] rdata;
        logic         err;
        bus_transfer(addr, 1'b1, data, rdata, err);
        if (err !== exp_err) begin
            errors++;
            $display("[ERROR] %0t: write 0x%02h pslverr %b, expected %b",
                     $time, addr, err, exp_err);
        end
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [W-1:0] exp,
                            input logic exp_err, input string what);
        logic [W-1:0] rdata;
        logic         err;
        bus_transfer(addr, 1'b0, '0, rdata, err);
        if (err !== exp_err) begin
            errors++;
            $display("[ERROR] %0t: %s pslverr %b, expected %b", $time, what, err, exp_err);
        end
        if (rdata !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s read 0x%08h, expected 0x%08h", $time, what, rdata, exp);
        end
    endtask

    // load operands, launch through CTRL, then check RESULT and FLAGS
    task automatic run_op(input logic [W-1:0] ra, input logic [W-1:0] rb,
                          input logic [W-1:0] ri, input logic src, input logic [4:0] op);
        logic [W+3:0] exp;
        logic [W-1:0] cw;
        exp = ref_alu(ra, src ? ri : rb, op);
        cw  = '0;
        cw[4:0] = op;
        cw[`EXE_CTRL_SRC_BIT] = src;
        apb_write(`EXE_REG_RS1, ra, 1'b0);
        apb_write(`EXE_REG_RS2, rb, 1'b0);
        apb_write(`EXE_REG_IMM, ri, 1'b0);
        apb_write(`EXE_REG_CTRL, cw, 1'b0);
        apb_read(`EXE_REG_RESULT, exp[W-1:0], 1'b0, $sformatf("op 0x%02h result", op));
        apb_read(`EXE_REG_FLAGS, W'(exp[W+3:W]), 1'b0, $sformatf("op 0x%02h flags", op));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_start_errors) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_start_errors);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        test_start_errors = errors;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        i_clk = 1'b0;
        i_reset = 1'b1;
        apb_req = '0;
        lcg_state = 32'd71;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_start_errors = 0;
        op_list = '{exe_alu_pkg::OP_ADD, exe_alu_pkg::OP_AND, exe_alu_pkg::OP_OR,
                    exe_alu_pkg::OP_XOR, exe_alu_pkg::OP_SLL, exe_alu_pkg::OP_SRL,
                    exe_alu_pkg::OP_SRA, exe_alu_pkg::OP_SUB, exe_alu_pkg::OP_SLT,
                    exe_alu_pkg::OP_SLTU};
        repeat (2) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        // registers sit at consecutive word offsets from 0x00 to 0x14
        for (int i = 0; i < 6; i++) begin
            apb_read(8'(i * 4), '0, 1'b0, $sformatf("reset 0x%02h", i * 4));
        end
        end_test("reset values");

        a    = lcg_next();
        rs2  = lcg_next();
        imm  = lcg_next();
        ctrl = lcg_next();
        apb_write(`EXE_REG_RS1, a, 1'b0);
        apb_write(`EXE_REG_RS2, rs2, 1'b0);
        apb_write(`EXE_REG_IMM, imm, 1'b0);
        apb_write(`EXE_REG_CTRL, ctrl, 1'b0);
        apb_read(`EXE_REG_RS1, a, 1'b0, "rs1");
        apb_read(`EXE_REG_RS2, rs2, 1'b0, "rs2");
        apb_read(`EXE_REG_IMM, imm, 1'b0, "imm");
        apb_read(`EXE_REG_CTRL, ctrl & (32'h1F | (32'h1 << `EXE_CTRL_SRC_BIT)), 1'b0, "ctrl");
        end_test("register readback");

        for (int n = 0; n < NUM_RANDOM; n++) begin
            a   = lcg_next();
            rs2 = lcg_next();
            imm = lcg_next();
            r   = lcg_next();
            run_op(a, rs2, imm, r[31], op_list[r[23:16] % 10]);
        end
        end_test("random operations");

        run_op(32'h7FFF_FFFF, 32'h1, '0, 1'b0, exe_alu_pkg::OP_ADD);
        run_op(32'h0, 32'h1, '0, 1'b0, exe_alu_pkg::OP_SUB);
        run_op(32'hFFFF_FFFF, 32'h1, '0, 1'b0, exe_alu_pkg::OP_ADD);
        run_op(32'h8000_0000, 32'h1, '0, 1'b0, exe_alu_pkg::OP_SUB);
        run_op(32'h8000_0000, '0, 32'h1, 1'b1, exe_alu_pkg::OP_SLT);
        run_op(32'h0, 32'hFFFF_FFFF, '0, 1'b0, exe_alu_pkg::OP_SLTU);
        end_test("flag corners");

        run_op(32'h1234_5678, 32'h11, 32'hCAFE_0003, 1'b0, exe_alu_pkg::OP_ADD);
        apb_write(8'h20, 32'hFFFF_FFFF, 1'b1);
        apb_read(8'h20, '0, 1'b1, "unmapped 0x20");
        apb_read(8'h02, '0, 1'b1, "unmapped 0x02");
        apb_write(`EXE_REG_RESULT, 32'hDEAD_BEEF, 1'b1);
        apb_write(`EXE_REG_FLAGS, 32'hF, 1'b1);
        apb_read(`EXE_REG_RS1, 32'h1234_5678, 1'b0, "rs1 after errors");
        apb_read(`EXE_REG_RS2, 32'h11, 1'b0, "rs2 after errors");
        apb_read(`EXE_REG_IMM, 32'hCAFE_0003, 1'b0, "imm after errors");
        apb_read(`EXE_REG_CTRL, 32'h0, 1'b0, "ctrl after errors");
        apb_read(`EXE_REG_RESULT, 32'h1234_5689, 1'b0, "result after errors");
        apb_read(`EXE_REG_FLAGS, 32'h0, 1'b0, "flags after errors");
        end_test("bus errors");

        run_op(32'hFFFF_0000, 32'h0000_FFFF, '0, 1'b0, 5'h07);
        run_op(32'h1357_9BDF, '0, 32'h2468_ACE0, 1'b1, 5'h1F);
        run_op(32'h8000_0001, 32'h3, '0, 1'b0, 5'h0C);
        end_test("undefined opcodes");

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verilog/exe_alu.sv ====
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_alu (
    input  exe_alu_pkg::alu_req_t   i_req,
    output logic [`EXE_DATA_W-1:0]  o_result,
    output exe_alu_pkg::alu_flags_t o_flags
);
    localparam int W = `EXE_DATA_W;

    logic         sub;
    logic [W-1:0] b_eff;
    logic [W-1:0] sum;
    logic [4:0]   shamt;
    logic         slt;
    logic         sltu;

    // subtract and compares use a + ~b + 1, inverted here only
    assign sub   = i_req.op[4];
    assign b_eff = sub ? ~i_req.b : i_req.b;
    assign shamt = i_req.b[4:0];

    kogge_stone_adder i_adder (
        .i_a     (i_req.a),
        .i_b     (b_eff),
        .i_cin   (sub),
        .o_sum   (sum),
        .o_flags (o_flags)
    );

    // compares read the flags of a - b
    assign slt  = o_flags.n ^ o_flags.v;
    assign sltu = ~o_flags.c;

    always_comb begin
        case (i_req.op)
            exe_alu_pkg::OP_ADD,
            exe_alu_pkg::OP_SUB:  o_result = sum;
            exe_alu_pkg::OP_AND:  o_result = i_req.a & i_req.b;
            exe_alu_pkg::OP_OR:   o_result = i_req.a | i_req.b;
            exe_alu_pkg::OP_XOR:  o_result = i_req.a ^ i_req.b;
            exe_alu_pkg::OP_SLL:  o_result = i_req.a << shamt;
            exe_alu_pkg::OP_SRL:  o_result = i_req.a >> shamt;
            // sign bit fills from the left
            exe_alu_pkg::OP_SRA:  o_result = $signed(i_req.a) >>> shamt;
            exe_alu_pkg::OP_SLT:  o_result = {{(W-1){1'b0}}, slt};
            exe_alu_pkg::OP_SLTU: o_result = {{(W-1){1'b0}}, sltu};
            default:              o_result = '0;
        endcase
    end

endmodule

// ==== verilog/exe_alu_pkg.sv ====
`include "exe_settings.svh"

package exe_alu_pkg;

    // bit 4 set means b is inverted and the adder gets a carry-in of one
    typedef enum logic [4:0] {
        OP_ADD  = 5'h00,
        OP_AND  = 5'h01,
        OP_OR   = 5'h02,
        OP_XOR  = 5'h03,
        OP_SLL  = 5'h04,
        OP_SRL  = 5'h05,
        OP_SRA  = 5'h06,
        OP_SUB  = 5'h10,
        OP_SLT  = 5'h17,
        OP_SLTU = 5'h18
    } alu_op_e;

    // n in bit 3 down to v in bit 0, same order as the FLAGS register
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } alu_flags_t;

    // b is already the selected operand (rs2 or immediate)
    typedef struct packed {
        logic [`EXE_DATA_W-1:0] a;
        logic [`EXE_DATA_W-1:0] b;
        alu_op_e                op;
    } alu_req_t;

endpackage

// ==== verilog/exe_apb_alu.sv ====
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_apb_alu (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  exe_apb_pkg::apb_req_t   i_apb,
    output exe_apb_pkg::apb_rsp_t   o_apb
);
    exe_alu_pkg::alu_req_t   alu_req;
    logic [`EXE_DATA_W-1:0]  alu_result;
    exe_alu_pkg::alu_flags_t alu_flags;

    // bus side, register file and result capture
    exe_apb_regs i_regs (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_apb        (i_apb),
        .o_apb        (o_apb),
        .o_alu_req    (alu_req),
        .i_alu_result (alu_result),
        .i_alu_flags  (alu_flags)
    );

    // purely combinational datapath
    exe_alu i_alu (
        .i_req    (alu_req),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

endmodule

// ==== verilog/exe_apb_pkg.sv ====
`include "exe_settings.svh"

package exe_apb_pkg;

    // master to slave
    typedef struct packed {
        logic [`EXE_ADDR_W-1:0] paddr;
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`EXE_DATA_W-1:0] pwdata;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic [`EXE_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // bus phase as seen by the slave
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_SETUP  = 2'd1,
        ST_ACCESS = 2'd2
    } apb_state_e;

endpackage

// ==== verilog/exe_apb_regs.sv ====
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_apb_regs (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  exe_apb_pkg::apb_req_t   i_apb,
    output exe_apb_pkg::apb_rsp_t   o_apb,
    output exe_alu_pkg::alu_req_t   o_alu_req,
    input  logic [`EXE_DATA_W-1:0]  i_alu_result,
    input  exe_alu_pkg::alu_flags_t i_alu_flags
);
    localparam int W    = `EXE_DATA_W;
    localparam int OP_W = $bits(exe_alu_pkg::alu_op_e);

    exe_apb_pkg::apb_state_e state_q;
    exe_apb_pkg::apb_state_e phase;

    logic [W-1:0]            rs1_q;
    logic [W-1:0]            rs2_q;
    logic [W-1:0]            imm_q;
    logic [OP_W-1:0]         ctrl_op_q;
    logic                    ctrl_src_q;
    logic [W-1:0]            result_q;
    exe_alu_pkg::alu_flags_t flags_q;
    logic                    launch_q;

    logic [W-1:0]            ctrl_word;
    logic [W-1:0]            rd_data;
    logic                    addr_ok;
    logic                    read_only;
    logic                    access;
    logic                    bad_access;
    logic                    wr_en;

    // current bus phase, an access only counts right after a setup
    always_comb begin
        if (i_apb.psel && !i_apb.penable) begin
            phase = exe_apb_pkg::ST_SETUP;
        end else if (i_apb.psel && state_q == exe_apb_pkg::ST_SETUP) begin
            phase = exe_apb_pkg::ST_ACCESS;
        end else begin
            phase = exe_apb_pkg::ST_IDLE;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= exe_apb_pkg::ST_IDLE;
        end else begin
            state_q <= phase;
        end
    end

    // control word as seen on a read
    always_comb begin
        ctrl_word                    = '0;
        ctrl_word[OP_W-1:0]          = ctrl_op_q;
        ctrl_word[`EXE_CTRL_SRC_BIT] = ctrl_src_q;
    end

    // address decode
    always_comb begin
        rd_data   = '0;
        addr_ok   = 1'b1;
        read_only = 1'b0;
        case (i_apb.paddr)
            `EXE_REG_RS1:    rd_data = rs1_q;
            `EXE_REG_RS2:    rd_data = rs2_q;
            `EXE_REG_IMM:    rd_data = imm_q;
            `EXE_REG_CTRL:   rd_data = ctrl_word;
            `EXE_REG_RESULT: begin
                rd_data   = result_q;
                read_only = 1'b1;
            end
            `EXE_REG_FLAGS:  begin
                rd_data   = {{(W-$bits(flags_q)){1'b0}}, flags_q};
                read_only = 1'b1;
            end
            default:         addr_ok = 1'b0;
        endcase
    end

    assign access     = (phase == exe_apb_pkg::ST_ACCESS);
    assign bad_access = !addr_ok || (read_only && i_apb.pwrite);
    assign wr_en      = access && i_apb.pwrite && !bad_access;

    // zero-wait slave, bad reads return zero
    assign o_apb = '{
        prdata:  (access && !i_apb.pwrite && !bad_access) ? rd_data : '0,
        pready:  access,
        pslverr: access && bad_access
    };

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rs1_q      <= '0;
            rs2_q      <= '0;
            imm_q      <= '0;
            ctrl_op_q  <= '0;
            ctrl_src_q <= 1'b0;
            result_q   <= '0;
            flags_q    <= '0;
            launch_q   <= 1'b0;
        end else begin
            launch_q <= 1'b0;
            if (wr_en) begin
                case (i_apb.paddr)
                    `EXE_REG_RS1: rs1_q <= i_apb.pwdata;
                    `EXE_REG_RS2: rs2_q <= i_apb.pwdata;
                    `EXE_REG_IMM: imm_q <= i_apb.pwdata;
                    `EXE_REG_CTRL: begin
                        ctrl_op_q  <= i_apb.pwdata[OP_W-1:0];
                        ctrl_src_q <= i_apb.pwdata[`EXE_CTRL_SRC_BIT];
                        launch_q   <= 1'b1;
                    end
                    default: ;
                endcase
            end
            // ALU inputs have settled on the new control word by now
            if (launch_q) begin
                result_q <= i_alu_result;
                flags_q  <= i_alu_flags;
            end
        end
    end

    assign o_alu_req = '{
        a:  rs1_q,
        b:  ctrl_src_q ? imm_q : rs2_q,
        op: exe_alu_pkg::alu_op_e'(ctrl_op_q)
    };

endmodule

// ==== verilog/exe_settings.svh ====
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// datapath and bus widths
`define EXE_DATA_W          32
`define EXE_ADDR_W          8

// register byte offsets on the APB side
`define EXE_REG_RS1         8'h00
`define EXE_REG_RS2         8'h04
`define EXE_REG_IMM         8'h08
`define EXE_REG_CTRL        8'h0C
`define EXE_REG_RESULT      8'h10
`define EXE_REG_FLAGS       8'h14

// operand b source select inside the control word
`define EXE_CTRL_SRC_BIT    8

`endif

// ==== verilog/kogge_stone_adder.sv ====
`timescale 1ns/1ps
`include "exe_settings.svh"

module kogge_stone_adder (
    input  logic [`EXE_DATA_W-1:0]  i_a,
    input  logic [`EXE_DATA_W-1:0]  i_b,
    input  logic                    i_cin,
    output logic [`EXE_DATA_W-1:0]  o_sum,
    output exe_alu_pkg::alu_flags_t o_flags
);
    localparam int W      = `EXE_DATA_W;
    localparam int STAGES = $clog2(W);

    // group generate and propagate, one row per prefix level
    wire  [W-1:0] grp_g [0:STAGES];
    wire  [W-1:0] grp_p [0:STAGES];
    logic [W-1:0] bit_p;
    logic [W-1:0] carry;

    assign bit_p    = i_a ^ i_b;
    assign grp_g[0] = i_a & i_b;
    assign grp_p[0] = bit_p;

    // each level doubles the span, low bits already complete pass through
    generate
        for (genvar s = 0; s < STAGES; s++) begin : g_stage
            for (genvar i = 0; i < W; i++) begin : g_bit
                if (i < (1 << s)) begin : g_pass
                    assign grp_g[s+1][i] = grp_g[s][i];
                    assign grp_p[s+1][i] = grp_p[s][i];
                end else begin : g_cell
                    assign grp_g[s+1][i] = grp_g[s][i]
                                         | (grp_p[s][i] & grp_g[s][i-(1<<s)]);
                    assign grp_p[s+1][i] = grp_p[s][i] & grp_p[s][i-(1<<s)];
                end
            end
        end
    endgenerate

    // carry out of bit i, carry-in enters through the full-span propagate
    assign carry = grp_g[STAGES] | (grp_p[STAGES] & {W{i_cin}});

    assign o_sum = bit_p ^ {carry[W-2:0], i_cin};

    // overflow when carry into and out of the sign bit differ
    assign o_flags = '{
        n: o_sum[W-1],
        z: (o_sum == '0),
        c: carry[W-1],
        v: carry[W-1] ^ carry[W-2]
    };

endmodule
